// File: disp_cfg.svh
/*
 * display build macros: digit count, segment count,
 * dot prescaler width and digit period length in dot ticks
 */
`ifndef DISP_CFG_SVH
`define DISP_CFG_SVH

// number of multiplexed digits on the board
`define DISP_DIGITS 4

// number of segments per digit, decimal point not driven
`define SEG_COUNT 7

// one dot tick every 2**DOT_DIV_BITS clock cycles
`define DOT_DIV_BITS 2

// one digit slot lasts 2**DIGIT_DOT_BITS dot ticks
`define DIGIT_DOT_BITS 4

`endif

// File: disp_pkg.sv
/*
 * display package: digit, segment and anode types
 * plus the hex to seven-segment glyph function
 */
`default_nettype none
`include "disp_cfg.svh"

package disp_pkg;

	typedef logic [3:0] hex_digit_t; // one hex nibble
	typedef logic [`SEG_COUNT-1:0] seg_pattern_t; // active low, bit 6 = a, bit 0 = g
	typedef logic [$clog2(`DISP_DIGITS)-1:0] digit_sel_t; // digit slot index
	typedef logic [`DISP_DIGITS-1:0] anode_t; // active high, bit 0 = least significant digit

	// segment order in a pattern is a b c d e f g, a 0 lights the segment
	function automatic seg_pattern_t glyph_of(input hex_digit_t digit);
		seg_pattern_t glyph;
		case (digit)
			4'h0:    glyph = 7'b0000001;
			4'h1:    glyph = 7'b1001111;
			4'h2:    glyph = 7'b0010010;
			4'h3:    glyph = 7'b0000110;
			4'h4:    glyph = 7'b1001100;
			4'h5:    glyph = 7'b0100100;
			4'h6:    glyph = 7'b0100000;
			4'h7:    glyph = 7'b0001111;
			4'h8:    glyph = 7'b0000000;
			4'h9:    glyph = 7'b0000100;
			4'ha:    glyph = 7'b0001000; // upper case A
			4'hb:    glyph = 7'b1100000; // lower case b
			4'hc:    glyph = 7'b0110001; // upper case C
			4'hd:    glyph = 7'b1000010; // lower case d
			4'he:    glyph = 7'b0110000; // upper case E
			default: glyph = 7'b0111000; // upper case F
		endcase
		return glyph;
	endfunction

endpackage

`default_nettype wire

// File: disp_if.sv
/*
 * disp_if: stored glyphs and scan ticks shared by the
 * intake, the scan timer and the segment scanner
 */
`timescale 1ns/10ps
`default_nettype none
`include "disp_cfg.svh"

interface disp_if
	import disp_pkg::*;
();

	seg_pattern_t [`DISP_DIGITS-1:0] glyphs; // decoded digits, entry 0 is the rightmost
	logic dot_tick; // one-cycle segment step enable
	logic digit_tick; // one-cycle slot change enable, always with a dot tick
	digit_sel_t digit_sel; // slot that opens on the next digit tick

	modport intake (
		output glyphs
	);

	modport timer (
		output dot_tick,
		output digit_tick,
		output digit_sel
	);

	modport scanner (
		input glyphs,
		input dot_tick,
		input digit_tick,
		input digit_sel
	);

endinterface

`default_nettype wire

// File: digit_intake.sv
/*
 * digit_intake: decodes each loaded hex digit and shifts
 * its glyph in from the right of the display
 */
`timescale 1ns/10ps
`default_nettype none
`include "disp_cfg.svh"

module digit_intake
	import disp_pkg::*;
(
	input logic CLK,
	input logic reset,
	input logic load,
	input hex_digit_t digit_in,
	disp_if.intake disp
);

	seg_pattern_t [`DISP_DIGITS-1:0] glyph_q; // one stored pattern per digit
	seg_pattern_t new_glyph;

	// decode on arrival so the scanner only ever sees segment patterns
	assign new_glyph = glyph_of(digit_in);

	always_ff @(posedge CLK) begin
		if (reset) begin
			for (int i = 0; i < `DISP_DIGITS; i++) begin
				glyph_q[i] <= '1; // blank digit
			end
		end else if (load) begin
			glyph_q[0] <= new_glyph; // newest digit on the right
			for (int i = 1; i < `DISP_DIGITS; i++) begin
				glyph_q[i] <= glyph_q[i-1]; // oldest digit drops off the left
			end
		end
	end

	assign disp.glyphs = glyph_q;

endmodule

`default_nettype wire

// File: scan_timer.sv
/*
 * scan_timer: free-running prescaler that issues dot ticks,
 * digit ticks and the digit slot index
 */
`timescale 1ns/10ps
`default_nettype none
`include "disp_cfg.svh"

module scan_timer
	import disp_pkg::*;
(
	input logic CLK,
	input logic reset,
	disp_if.timer disp
);

	localparam int SLOT_W = `DOT_DIV_BITS + `DIGIT_DOT_BITS; // clocks per slot, log2
	localparam int CNT_W = SLOT_W + $bits(digit_sel_t);

	logic [CNT_W-1:0] count_q;
	logic [CNT_W-1:0] count_next;
	logic dot_tick_q;
	logic digit_tick_q;

	assign count_next = count_q + CNT_W'(1);

	// ticks are decoded from the next count so they line up with the
	// cycle in which the counter field is all ones
	always_ff @(posedge CLK) begin
		if (reset) begin
			count_q <= '0;
			dot_tick_q <= 1'b0;
			digit_tick_q <= 1'b0;
		end else begin
			count_q <= count_next;
			dot_tick_q <= &count_next[`DOT_DIV_BITS-1:0];
			digit_tick_q <= &count_next[SLOT_W-1:0]; // last dot of the slot
		end
	end

	assign disp.dot_tick = dot_tick_q;
	assign disp.digit_tick = digit_tick_q;
	assign disp.digit_sel = digit_sel_t'(count_q[CNT_W-1:SLOT_W]); // upper field

	// the scanner blanks and rotates on the same dot, so a slot change off a dot breaks it
	digit_on_dot: assert property (@(posedge CLK) disable iff (reset)
		digit_tick_q |-> dot_tick_q)
		else $error("digit tick without dot tick");

endmodule

`default_nettype wire

// File: segment_scanner.sv
/*
 * segment_scanner: digit multiplex on the anodes and a one-hot
 * token that lights at most one segment of the slot glyph
 */
`timescale 1ns/10ps
`default_nettype none
`include "disp_cfg.svh"

module segment_scanner
	import disp_pkg::*;
(
	input logic CLK,
	input logic reset,
	disp_if.scanner disp,
	output seg_pattern_t segments,
	output anode_t anodes
);

	localparam seg_pattern_t TOKEN_A = seg_pattern_t'(1) << (`SEG_COUNT - 1); // segment a

	anode_t anode_q;
	seg_pattern_t seg_q;
	seg_pattern_t slot_q; // glyph latched for the whole slot
	seg_pattern_t token_q; // one-hot, same bit order as the pattern
	seg_pattern_t token_next;
	anode_t anode_next;

	// a..g sits at bit 6..0, so stepping a to b is a rotate right
	assign token_next = {token_q[0], token_q[`SEG_COUNT-1:1]};
	assign anode_next = anode_t'(1) << disp.digit_sel;

	always_ff @(posedge CLK) begin
		if (reset) begin
			anode_q <= '0; // all digits off
			seg_q <= '1; // all segments off
			slot_q <= '1; // blank until the first slot opens
			token_q <= TOKEN_A;
		end else if (disp.digit_tick) begin
			anode_q <= anode_next;
			slot_q <= disp.glyphs[disp.digit_sel];
			seg_q <= '1; // nothing of the old digit under the new anode
			token_q <= TOKEN_A; // each slot starts its walk at a
		end else if (disp.dot_tick) begin
			seg_q <= slot_q | ~token_q; // only the token segment may go low
			token_q <= token_next;
		end
	end

	assign segments = seg_q;
	assign anodes = anode_q;

	// peak current allows one digit and one segment at a time
	anodes_onehot0: assert property (@(posedge CLK) disable iff (reset)
		$onehot0(anode_q))
		else $error("more than one anode on: %h", anode_q);

	segments_one_lit: assert property (@(posedge CLK) disable iff (reset)
		$countones(~seg_q) <= 1)
		else $error("more than one segment lit: %h", seg_q);

endmodule

`default_nettype wire

// File: seven_seg_top.sv
/*
 * seven_seg_top: four-digit hex display driver, digit intake,
 * scan timer and segment scanner joined by disp_if
 */
`timescale 1ns/10ps
`default_nettype none

module seven_seg_top
	import disp_pkg::*;
(
	input logic CLK,
	input logic reset,
	input logic load, // one-cycle strobe, always accepted
	input hex_digit_t digit_in,
	output seg_pattern_t segments, // active low
	output anode_t anodes // active high
);

	disp_if disp_bus ();

	digit_intake intake0 (
		.CLK      (CLK),
		.reset    (reset),
		.load     (load),
		.digit_in (digit_in),
		.disp     (disp_bus.intake)
	);

	scan_timer timer0 (
		.CLK   (CLK),
		.reset (reset),
		.disp  (disp_bus.timer)
	);

	segment_scanner scanner0 (
		.CLK      (CLK),
		.reset    (reset),
		.disp     (disp_bus.scanner),
		.segments (segments),
		.anodes   (anodes)
	);

endmodule

`default_nettype wire

// File: tb_seven_seg.sv
/*
 * tb_seven_seg: directed testbench for the seven-segment driver
 * with a digit model, a slot monitor, an LCG and a watchdog
 */
`timescale 1ns/10ps
`default_nettype none
`include "disp_cfg.svh"

module tb_seven_seg
	import disp_pkg::*;
();

	localparam int CLK_PERIOD = 40;
	localparam int SLOT_CYCLES = (1 << `DOT_DIV_BITS) << `DIGIT_DOT_BITS; // 64 clocks per anode
	localparam int MAX_GAP = 256; // random idle cycles between loads
	localparam int RANDOM_LOADS = 20;
	localparam int TOTAL_SLOTS = 4 + 8 + 12 + 12 + RANDOM_LOADS * (MAX_GAP / SLOT_CYCLES + 2) + 8;
	localparam int WATCHDOG_CYCLES = TOTAL_SLOTS * SLOT_CYCLES + 2000;

	logic CLK;
	logic reset;
	logic load;
	hex_digit_t digit_in;
	seg_pattern_t segments;
	anode_t anodes;

	// digit model with the newest digit in entry 0
	hex_digit_t model_digit [`DISP_DIGITS];
	logic [`DISP_DIGITS-1:0] model_loaded;
	int load_count; // bumped once a load has been taken by the DUT

	logic [31:0] lcg_state;
	int tb_mismatches;

	// slot monitor state
	logic seen_first; // first anode change after reset seen
	anode_t prev_anodes;
	int prev_idx;
	int new_idx;
	int slot_cycles;
	int slot_loads; // loads taken before the slot opened
	int loads_seen; // load_count at the previous sample
	int checked_slots;
	int lit_count;
	seg_pattern_t lit_union; // a zero marks a segment seen lit
	int mon_mismatches;
	int mon_failures;

	seven_seg_top dut0 (
		.CLK      (CLK),
		.reset    (reset),
		.load     (load),
		.digit_in (digit_in),
		.segments (segments),
		.anodes   (anodes)
	);

	initial begin
		CLK = 1'b0;
		forever #(CLK_PERIOD / 2) CLK = ~CLK;
	end

	// lit segments per hex value with a..g at bit 6..0 and a one for lit
	function automatic logic [6:0] lit_mask_of(input hex_digit_t value);
		logic [6:0] mask;
		case (value)
			4'h0:    mask = 7'b1111110;
			4'h1:    mask = 7'b0110000;
			4'h2:    mask = 7'b1101101;
			4'h3:    mask = 7'b1111001;
			4'h4:    mask = 7'b0110011;
			4'h5:    mask = 7'b1011011;
			4'h6:    mask = 7'b1011111;
			4'h7:    mask = 7'b1110000;
			4'h8:    mask = 7'b1111111;
			4'h9:    mask = 7'b1111011;
			4'ha:    mask = 7'b1110111;
			4'hb:    mask = 7'b0011111;
			4'hc:    mask = 7'b1001110;
			4'hd:    mask = 7'b0111101;
			4'he:    mask = 7'b1001111;
			default: mask = 7'b1000111;
		endcase
		return mask;
	endfunction

	function automatic seg_pattern_t expected_glyph(input int idx);
		seg_pattern_t glyph;
		glyph = '1; // blank until a digit lands here
		if (idx >= 0 && idx < `DISP_DIGITS) begin
			if (model_loaded[idx]) glyph = ~lit_mask_of(model_digit[idx]);
		end
		return glyph;
	endfunction

	function automatic int active_digit(input anode_t a);
		int idx;
		idx = -1;
		if ($onehot(a)) begin
			for (int i = 0; i < `DISP_DIGITS; i++) begin
				if (a[i]) idx = i;
			end
		end
		return idx;
	endfunction

	function automatic logic [31:0] next_rand();
		lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
		return lcg_state;
	endfunction

	function automatic int total_errors();
		return tb_mismatches + mon_mismatches + mon_failures;
	endfunction

	task automatic print_error_counts();
		$display("errors: %0d mismatches, %0d other failures",
			tb_mismatches + mon_mismatches, mon_failures);
	endtask

	// samples between edges and checks every cycle and each finished slot
	always @(negedge CLK) begin
		if (reset) begin
			seen_first = 1'b0;
			prev_anodes = '0;
			prev_idx = -1;
			slot_cycles = 0;
			slot_loads = load_count;
			loads_seen = load_count;
			lit_union = '1;
		end else begin
			slot_cycles++;
			lit_count = $countones(~segments);
			assert ($onehot0(anodes)) else begin
				mon_failures++;
				$display("more than one anode active at %0t, anodes = %h", $time, anodes);
			end
			assert (lit_count <= 1) else begin
				mon_failures++;
				$display("%0d segments lit at once at %0t, segments = %h",
					lit_count, $time, segments);
			end
			if (!seen_first && anodes == '0) begin
				assert (segments == '1) else begin
					mon_mismatches++;
					$display("Mismatch segments before first slot: got %h, expected %h",
						segments, 7'h7f);
				end
			end
			if (anodes != prev_anodes) begin
				new_idx = active_digit(anodes);
				if (seen_first) begin
					assert (slot_cycles == SLOT_CYCLES) else begin
						mon_failures++;
						$display("slot of digit %0d lasted %0d cycles instead of %0d",
							prev_idx, slot_cycles, SLOT_CYCLES);
					end
					if (slot_loads == load_count) begin // no load while the slot ran
						assert (lit_union == expected_glyph(prev_idx)) else begin
							mon_mismatches++;
							$display("Mismatch segments union of digit %0d: got %h, expected %h",
								prev_idx, lit_union, expected_glyph(prev_idx));
						end
						checked_slots++;
					end
					assert (new_idx == (prev_idx + 1) % `DISP_DIGITS) else begin
						mon_failures++;
						$display("anode order broken: digit %0d followed digit %0d",
							new_idx, prev_idx);
					end
				end else begin
					assert (new_idx == 0) else begin
						mon_failures++;
						$display("first slot after reset is not digit 0, anodes = %h", anodes);
					end
				end
				assert (segments == '1) else begin
					mon_mismatches++;
					$display("Mismatch segments at slot start: got %h, expected %h",
						segments, 7'h7f);
				end
				seen_first = 1'b1;
				prev_anodes = anodes;
				prev_idx = new_idx;
				slot_cycles = 0;
				slot_loads = loads_seen; // a load at the opening edge misses the latched glyph
				lit_union = '1;
			end
			lit_union = lit_union & segments;
			loads_seen = load_count;
		end
	end

	task automatic wait_slots(input int count);
		int target;
		target = checked_slots + count;
		while (checked_slots < target) @(posedge CLK);
	endtask

	task automatic load_digit(input hex_digit_t value);
		@(posedge CLK);
		#2;
		load = 1'b1;
		digit_in = value;
		@(posedge CLK);
		#2;
		load = 1'b0;
		for (int i = `DISP_DIGITS - 1; i > 0; i--) begin
			model_digit[i] = model_digit[i-1];
		end
		model_digit[0] = value;
		model_loaded = {model_loaded[`DISP_DIGITS-2:0], 1'b1};
		load_count++;
	endtask

	task automatic test_reset();
		reset = 1'b1;
		for (int i = 0; i < 5; i++) begin
			@(posedge CLK);
			#2;
			assert (anodes == '0) else begin
				tb_mismatches++;
				$display("Mismatch anodes in reset: got %h, expected %h", anodes, 4'h0);
			end
			assert (segments == '1) else begin
				tb_mismatches++;
				$display("Mismatch segments in reset: got %h, expected %h", segments, 7'h7f);
			end
		end
		reset = 1'b0;
		wait_slots(4); // one frame of blank digits
	endtask

	task automatic test_multiplex();
		anode_t start;
		int first_idx;
		@(posedge CLK);
		#2;
		start = anodes;
		first_idx = active_digit(start);
		for (int k = 1; k <= 2 * `DISP_DIGITS; k++) begin
			while (anodes == start) begin
				@(posedge CLK);
				#2;
			end
			assert (anodes == anode_t'(1 << ((first_idx + k) % `DISP_DIGITS))) else begin
				tb_mismatches++;
				$display("Mismatch anodes: got %h, expected %h", anodes,
					anode_t'(1 << ((first_idx + k) % `DISP_DIGITS)));
			end
			start = anodes;
		end
	endtask

	task automatic test_glyphs();
		load_digit(4'h0);
		load_digit(4'h1);
		load_digit(4'h8);
		load_digit(4'hf);
		wait_slots(12); // three frames
	endtask

	task automatic test_shift();
		load_digit(4'hc);
		load_digit(4'h5);
		load_digit(4'hd);
		load_digit(4'h2);
		wait_slots(4);
		load_digit(4'he); // c drops off the left
		wait_slots(8);
	endtask

	task automatic test_random();
		logic [31:0] r;
		int gap;
		for (int n = 0; n < RANDOM_LOADS; n++) begin
			r = next_rand();
			gap = int'(r[27:20]);
			repeat (gap) @(posedge CLK);
			r = next_rand();
			load_digit(r[19:16]);
		end
		wait_slots(8);
	endtask

	initial begin
		#(WATCHDOG_CYCLES * CLK_PERIOD);
		$display("timeout: tests did not finish within %0d cycles", WATCHDOG_CYCLES);
		print_error_counts();
		$display("Test failed");
		$finish;
	end

	initial begin
		reset = 1'b1;
		load = 1'b0;
		digit_in = '0;
		load_count = 0;
		model_loaded = '0;
		for (int i = 0; i < `DISP_DIGITS; i++) begin
			model_digit[i] = '0;
		end
		lcg_state = 32'h4a8f56de;
		tb_mismatches = 0;
		mon_mismatches = 0;
		mon_failures = 0;
		checked_slots = 0;
		test_reset();
		test_multiplex();
		test_glyphs();
		test_shift();
		test_random();
		print_error_counts();
		if (total_errors() == 0) begin
			$display("Test passed");
		end else begin
			$display("Test failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

// File: flist.f
+incdir+.
disp_pkg.sv
disp_if.sv
digit_intake.sv
scan_timer.sv
segment_scanner.sv
seven_seg_top.sv
tb_seven_seg.sv

// File: run_sim.sh
#!/usr/bin/env bash
# build the seven-segment testbench with Verilator, run it and judge the log

cd "$(dirname "$0")" || exit 1

LOG=sim.log
BIN=sim_seven_seg

verilator --binary --timing --assert \
	-f flist.f \
	--top-module tb_seven_seg \
	-o "$BIN"
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi

./obj_dir/"$BIN" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -q "Test failed" "$LOG"; then
	echo "simulation reported failure"
	exit 1
fi

if ! grep -q "Test passed" "$LOG"; then
	echo "simulation ended without a result"
	exit 1
fi

exit 0
